/* design/complexExecutionLane.sv */
/*
 * One complex-integer execution lane.
 * Computes multiply low/high and divide/remainder in a single cycle and
 * registers the result for the write stage under stall and clear.
 */
`timescale 1ns/1ps

module complexExecutionLane (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input complexOpTypes::LaneOp laneOp,
    output complexOpTypes::LaneResult laneResult
);
    import complexOpTypes::*;

    // Operands widened by one bit so one signed multiplier covers all forms
    logic signed [DATA_WIDTH:0] extA;
    logic signed [DATA_WIDTH:0] extB;
    logic signed [2*DATA_WIDTH+1:0] product;
    DataPath mulData;

    logic divByZero;
    logic divOverflow;
    DataPath quotient;
    DataPath remainder;
    DataPath divData;

    DataPath result;
    LaneResult resultReg;

    // Multiply path
    always_comb begin
        extA = {laneOp.opCode.mulCode.srcASigned & laneOp.srcA[DATA_WIDTH-1], laneOp.srcA};
        extB = {laneOp.opCode.mulCode.srcBSigned & laneOp.srcB[DATA_WIDTH-1], laneOp.srcB};
        product = extA * extB;
        if (laneOp.opCode.mulCode.highHalf) begin
            mulData = product[2*DATA_WIDTH-1:DATA_WIDTH];
        end else begin
            mulData = product[DATA_WIDTH-1:0];
        end
    end

    // Divide path with the two corner cases
    always_comb begin
        divByZero = (laneOp.srcB == '0);
        divOverflow = laneOp.opCode.divCode.isSigned &&
                      (laneOp.srcA == {1'b1, {(DATA_WIDTH-1){1'b0}}}) &&
                      (&laneOp.srcB);

        if (divByZero) begin
            quotient = '1;
            remainder = laneOp.srcA;
        end else if (divOverflow) begin
            // Most negative / -1 overflows, keep the dividend
            quotient = laneOp.srcA;
            remainder = '0;
        end else if (laneOp.opCode.divCode.isSigned) begin
            quotient = $signed(laneOp.srcA) / $signed(laneOp.srcB);
            remainder = $signed(laneOp.srcA) % $signed(laneOp.srcB);
        end else begin
            quotient = laneOp.srcA / laneOp.srcB;
            remainder = laneOp.srcA % laneOp.srcB;
        end

        if (laneOp.opCode.divCode.isRem) begin
            divData = remainder;
        end else begin
            divData = quotient;
        end
    end

    // isDiv reads the same bit in either view
    assign result = laneOp.opCode.divCode.isDiv ? divData : mulData;

    always_ff @(posedge ctrl) begin
        if (!rstN) begin
            resultReg.valid <= 1'b0;
        end else if (!stall) begin
            resultReg.valid <= laneOp.valid && !clear;
            resultReg.dataValid <= laneOp.operandsReady;
            resultReg.data <= result;
            resultReg.writeReg <= laneOp.writeReg;
            resultReg.phyDstRegNum <= laneOp.phyDstRegNum;
            resultReg.activeListPtr <= laneOp.activeListPtr;
        end
    end

    assign laneResult = resultReg;

endmodule

/* design/complexIntegerPipe.sv */
/*
 * Top of the complex-integer back end.
 * Issue register feeding a row of identical execution lanes, drained by
 * the register-write stage. Stall and clear reach every stage.
 */
`timescale 1ns/1ps

module complexIntegerPipe (
    input logic ctrl,
    input logic rstN,
    input complexOpTypes::IssuedOp issue [complexOpTypes::COMPLEX_ISSUE_WIDTH],
    input logic stall,
    input logic clear,
    input recoveryTypes::RecoveryRequest recovery,
    output complexOpTypes::RegWrite regWrite [complexOpTypes::COMPLEX_ISSUE_WIDTH],
    output recoveryTypes::ActiveListWrite activeListWrite [complexOpTypes::COMPLEX_ISSUE_WIDTH]
);
    import complexOpTypes::*;

    LaneOp laneOp [COMPLEX_ISSUE_WIDTH];
    LaneResult laneResult [COMPLEX_ISSUE_WIDTH];

    complexIssueRegister issueReg0 (
        .ctrl(ctrl),
        .rstN(rstN),
        .stall(stall),
        .clear(clear),
        .issue(issue),
        .laneOp(laneOp)
    );

    for (genvar i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin : lane
        complexExecutionLane lane0 (
            .ctrl(ctrl),
            .rstN(rstN),
            .stall(stall),
            .clear(clear),
            .laneOp(laneOp[i]),
            .laneResult(laneResult[i])
        );
    end

    complexRegisterWriteStage writeStage0 (
        .ctrl(ctrl),
        .rstN(rstN),
        .stall(stall),
        .clear(clear),
        .recovery(recovery),
        .laneResult(laneResult),
        .regWrite(regWrite),
        .activeListWrite(activeListWrite)
    );

endmodule

/* design/complexIssueRegister.sv */
/*
 * Issue pipeline register for the complex-integer lanes.
 * Decodes each raw scheduler opcode into the shared control word and
 * latches one op per lane under the global stall and clear.
 */
`timescale 1ns/1ps

module complexIssueRegister (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input complexOpTypes::IssuedOp issue [complexOpTypes::COMPLEX_ISSUE_WIDTH],
    output complexOpTypes::LaneOp laneOp [complexOpTypes::COMPLEX_ISSUE_WIDTH]
);
    import complexOpTypes::*;

    LaneOp decoded [COMPLEX_ISSUE_WIDTH];
    LaneOp pipeReg [COMPLEX_ISSUE_WIDTH];

    function automatic ComplexOpCode decodeOp(input RawComplexOp rawOp);
        ComplexOpCode code;

        code = '0;
        case (rawOp)
            RAW_MULH: code.mulCode = '{isDiv: 1'b0, highHalf: 1'b1,
                                       srcASigned: 1'b1, srcBSigned: 1'b1};
            RAW_MULHSU: code.mulCode = '{isDiv: 1'b0, highHalf: 1'b1,
                                         srcASigned: 1'b1, srcBSigned: 1'b0};
            RAW_MULHU: code.mulCode = '{isDiv: 1'b0, highHalf: 1'b1,
                                        srcASigned: 1'b0, srcBSigned: 1'b0};
            RAW_DIV: code.divCode = '{isDiv: 1'b1, isRem: 1'b0, isSigned: 1'b1, spare: 1'b0};
            RAW_DIVU: code.divCode = '{isDiv: 1'b1, isRem: 1'b0, isSigned: 1'b0, spare: 1'b0};
            RAW_REM: code.divCode = '{isDiv: 1'b1, isRem: 1'b1, isSigned: 1'b1, spare: 1'b0};
            RAW_REMU: code.divCode = '{isDiv: 1'b1, isRem: 1'b1, isSigned: 1'b0, spare: 1'b0};
            // MUL and the unused codes 8..15, low half is sign independent
            default: code.mulCode = '{isDiv: 1'b0, highHalf: 1'b0,
                                      srcASigned: 1'b1, srcBSigned: 1'b1};
        endcase
        return code;
    endfunction

    always_comb begin
        for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
            decoded[i].valid = issue[i].valid;
            decoded[i].opCode = decodeOp(issue[i].rawOp);
            decoded[i].srcA = issue[i].srcA;
            decoded[i].srcB = issue[i].srcB;
            decoded[i].operandsReady = issue[i].operandsReady;
            decoded[i].writeReg = issue[i].writeReg;
            decoded[i].phyDstRegNum = issue[i].phyDstRegNum;
            decoded[i].activeListPtr = issue[i].activeListPtr;
        end
    end

    always_ff @(posedge ctrl) begin
        if (!rstN) begin
            for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
                pipeReg[i] <= decoded[i];
                pipeReg[i].valid <= decoded[i].valid && !clear;
            end
        end
    end

    assign laneOp = pipeReg;

endmodule

/* design/complexOpTypes.sv */
/*
 * Operation types for the complex-integer back end.
 * Holds datapath widths, the raw and decoded opcodes, the op records that
 * travel from issue to the lanes and on to the write stage, and the
 * register-file write record. Compile after the retirement types.
 */
package complexOpTypes;

    localparam int DATA_WIDTH = 32;
    localparam int COMPLEX_ISSUE_WIDTH = 2;
    localparam int PHY_REG_NUM_WIDTH = 6;

    typedef logic [DATA_WIDTH-1:0] DataPath;
    typedef logic [PHY_REG_NUM_WIDTH-1:0] PhyRegNum;

    // Opcode as delivered by the scheduler
    typedef logic [3:0] RawComplexOp;

    localparam RawComplexOp RAW_MUL = 4'd0;
    localparam RawComplexOp RAW_MULH = 4'd1;
    localparam RawComplexOp RAW_MULHSU = 4'd2;
    localparam RawComplexOp RAW_MULHU = 4'd3;
    localparam RawComplexOp RAW_DIV = 4'd4;
    localparam RawComplexOp RAW_DIVU = 4'd5;
    localparam RawComplexOp RAW_REM = 4'd6;
    localparam RawComplexOp RAW_REMU = 4'd7;

    // Multiplier reading of the control word
    typedef struct packed {
        logic isDiv;
        logic highHalf;
        logic srcASigned;
        logic srcBSigned;
    } MulCode;

    // Divider reading of the same word, isDiv shares the top bit
    typedef struct packed {
        logic isDiv;
        logic isRem;
        logic isSigned;
        logic spare;
    } DivCode;

    typedef union packed {
        MulCode mulCode;
        DivCode divCode;
    } ComplexOpCode;

    typedef struct packed {
        logic valid;
        RawComplexOp rawOp;
        DataPath srcA;
        DataPath srcB;
        logic operandsReady;
        logic writeReg;
        PhyRegNum phyDstRegNum;
        logic [recoveryTypes::ACTIVE_LIST_PTR_WIDTH-1:0] activeListPtr;
    } IssuedOp;

    // Same op after decode, as seen by a lane
    typedef struct packed {
        logic valid;
        ComplexOpCode opCode;
        DataPath srcA;
        DataPath srcB;
        logic operandsReady;
        logic writeReg;
        PhyRegNum phyDstRegNum;
        logic [recoveryTypes::ACTIVE_LIST_PTR_WIDTH-1:0] activeListPtr;
    } LaneOp;

    typedef struct packed {
        logic valid;
        logic dataValid;
        DataPath data;
        logic writeReg;
        PhyRegNum phyDstRegNum;
        logic [recoveryTypes::ACTIVE_LIST_PTR_WIDTH-1:0] activeListPtr;
    } LaneResult;

    // Physical register file write port
    typedef struct packed {
        logic we;
        PhyRegNum regNum;
        DataPath data;
    } RegWrite;

endpackage

/* design/complexRegisterWriteStage.sv */
/*
 * Register-write stage of the complex-integer lanes.
 * Latches each lane result, drops ops caught by a selective flush and
 * drives the physical register file and active-list write ports.
 */
`timescale 1ns/1ps

module complexRegisterWriteStage (
    input logic ctrl,
    input logic rstN,
    input logic stall,
    input logic clear,
    input recoveryTypes::RecoveryRequest recovery,
    input complexOpTypes::LaneResult laneResult [complexOpTypes::COMPLEX_ISSUE_WIDTH],
    output complexOpTypes::RegWrite regWrite [complexOpTypes::COMPLEX_ISSUE_WIDTH],
    output recoveryTypes::ActiveListWrite activeListWrite [complexOpTypes::COMPLEX_ISSUE_WIDTH]
);
    import complexOpTypes::*;
    import recoveryTypes::*;

    LaneResult pipeReg [COMPLEX_ISSUE_WIDTH];
    logic flush [COMPLEX_ISSUE_WIDTH];
    logic update [COMPLEX_ISSUE_WIDTH];

    always_ff @(posedge ctrl) begin
        if (!rstN) begin
            for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
                pipeReg[i] <= laneResult[i];
                pipeReg[i].valid <= laneResult[i].valid && !clear;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
            // Flush is checked against the live recovery request
            flush[i] = selectiveFlush(recovery, pipeReg[i].activeListPtr);
            update[i] = !stall && !clear && pipeReg[i].valid && !flush[i];

            regWrite[i].we = update[i] && pipeReg[i].writeReg;
            regWrite[i].regNum = pipeReg[i].phyDstRegNum;
            regWrite[i].data = pipeReg[i].data;

            // Active list is told even when no register is written
            activeListWrite[i].write = update[i];
            activeListWrite[i].ptr = pipeReg[i].activeListPtr;
            if (update[i] && pipeReg[i].dataValid) begin
                activeListWrite[i].state = EXEC_STATE_SUCCESS;
            end else begin
                activeListWrite[i].state = EXEC_STATE_NOT_FINISHED;
            end
        end
    end

endmodule

/* design/recoveryTypes.sv */
/*
 * Retirement and recovery types for the complex-integer back end.
 * Active-list pointer, execution state, active-list write record and the
 * recovery request with its selective-flush range test.
 */
package recoveryTypes;

    localparam int ACTIVE_LIST_PTR_WIDTH = 5;

    typedef logic [ACTIVE_LIST_PTR_WIDTH-1:0] ActiveListPtr;

    typedef enum logic {
        EXEC_STATE_NOT_FINISHED,
        EXEC_STATE_SUCCESS
    } ExecState;

    // Flush range runs from head up to but not including tail
    typedef struct packed {
        logic toRecoveryPhase;
        ActiveListPtr flushHeadPtr;
        ActiveListPtr flushTailPtr;
    } RecoveryRequest;

    typedef struct packed {
        logic write;
        ActiveListPtr ptr;
        ExecState state;
    } ActiveListWrite;

    // True when ptr lies in the circular range [head, tail) during recovery
    function automatic logic selectiveFlush(
        input RecoveryRequest recovery,
        input ActiveListPtr ptr
    );
        logic inRange;

        if (recovery.flushHeadPtr <= recovery.flushTailPtr) begin
            // Plain range, empty when head equals tail
            inRange = (ptr >= recovery.flushHeadPtr) && (ptr < recovery.flushTailPtr);
        end else begin
            // Range wraps past the end of the list
            inRange = (ptr >= recovery.flushHeadPtr) || (ptr < recovery.flushTailPtr);
        end
        return recovery.toRecoveryPhase && inRange;
    endfunction

endpackage

/* sources.f */
design/recoveryTypes.sv
design/complexOpTypes.sv
design/complexIssueRegister.sv
design/complexExecutionLane.sv
design/complexRegisterWriteStage.sv
design/complexIntegerPipe.sv
verification/complexPipeTb.sv

/* verification/complexPipeTb.sv */
/*
 * Self-checking testbench for the complex-integer back end.
 * LCG stimulus drives both lanes and a shadow pipeline per lane predicts
 * every register-file and active-list write, checked each cycle.
 */
`timescale 1ns/1ps

module complexPipeTb;
    import complexOpTypes::*;
    import recoveryTypes::*;

    localparam int MODE_RESET = 0;
    localparam int MODE_ARITH = 1;
    localparam int MODE_READY = 2;
    localparam int MODE_STALL = 3;
    localparam int MODE_FLUSH = 4;
    localparam int TOTAL_CYCLES = 12 + 300 + 150 + 250 + 250;

    typedef struct packed {
        logic valid;
        logic dataValid;
        DataPath data;
        logic writeReg;
        PhyRegNum regNum;
        ActiveListPtr ptr;
    } ShadowEntry;

    logic ctrl;
    logic rstN;
    logic stall;
    logic clear;
    IssuedOp issue [COMPLEX_ISSUE_WIDTH];
    RecoveryRequest recovery;
    RegWrite regWrite [COMPLEX_ISSUE_WIDTH];
    ActiveListWrite activeListWrite [COMPLEX_ISSUE_WIDTH];

    // Stimulus for the coming cycle and the copy the DUT currently sees
    IssuedOp nextIssue [COMPLEX_ISSUE_WIDTH];
    IssuedOp curIssue [COMPLEX_ISSUE_WIDTH];
    logic nextRstN, nextStall, nextClear, curRstN, curStall, curClear;
    RecoveryRequest nextRecovery, curRecovery;
    ShadowEntry shadow [COMPLEX_ISSUE_WIDTH][3];
    logic [31:0] lcgState;
    int windowLeft;
    int checkCount;
    int errorCount;

    complexIntegerPipe dut0 (
        .ctrl(ctrl), .rstN(rstN), .issue(issue), .stall(stall), .clear(clear),
        .recovery(recovery), .regWrite(regWrite), .activeListWrite(activeListWrite)
    );

    initial begin
        ctrl = 1'b0;
        forever #10 ctrl = ~ctrl;
    end

    initial begin
        #((TOTAL_CYCLES + 100) * 20);
        $display("Timeout: the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Corner values appear often enough to hit the divide rules
    function automatic DataPath pickOperand();
        logic [31:0] r;
        DataPath value;
        r = lcgNext();
        case (r[30:28])
            3'd0: value = '0;
            3'd1: value = '1;
            3'd2: value = {1'b1, {(DATA_WIDTH-1){1'b0}}};
            default: value = lcgNext();
        endcase
        return value;
    endfunction

    function automatic DataPath expectedData(input RawComplexOp op, input DataPath a,
                                             input DataPath b);
        logic [2*DATA_WIDTH-1:0] wideA, wideB, wide;
        logic signedDiv, negA, negB;
        DataPath magA, magB, q, r, res;
        wideA = {{DATA_WIDTH{(op == RAW_MULH || op == RAW_MULHSU) && a[DATA_WIDTH-1]}}, a};
        wideB = {{DATA_WIDTH{(op == RAW_MULH) && b[DATA_WIDTH-1]}}, b};
        wide = wideA * wideB;
        signedDiv = (op == RAW_DIV) || (op == RAW_REM);
        negA = signedDiv && a[DATA_WIDTH-1];
        negB = signedDiv && b[DATA_WIDTH-1];
        magA = negA ? -a : a;
        magB = negB ? -b : b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (signedDiv && a == {1'b1, {(DATA_WIDTH-1){1'b0}}} && b == '1) begin
            q = a;
            r = '0;
        end else begin
            // Truncating division, remainder keeps the dividend's sign
            q = magA / magB;
            r = magA % magB;
            if (negA != negB) q = -q;
            if (negA) r = -r;
        end
        case (op)
            RAW_MULH, RAW_MULHSU, RAW_MULHU: res = wide[2*DATA_WIDTH-1:DATA_WIDTH];
            RAW_DIV, RAW_DIVU: res = q;
            RAW_REM, RAW_REMU: res = r;
            default: res = wide[DATA_WIDTH-1:0];
        endcase
        return res;
    endfunction

    function automatic logic ptrInFlush(input RecoveryRequest rec, input ActiveListPtr ptr);
        ActiveListPtr offset, span;
        offset = ptr - rec.flushHeadPtr;
        span = rec.flushTailPtr - rec.flushHeadPtr;
        return rec.toRecoveryPhase && (offset < span);
    endfunction

    function automatic IssuedOp randomIssue(input int mode);
        IssuedOp op;
        logic [31:0] r;
        r = lcgNext();
        op.valid = (r[31:29] != 3'd0);
        op.rawOp = {r[23] & r[22], r[26:24]};
        op.srcA = pickOperand();
        op.srcB = pickOperand();
        op.operandsReady = (mode == MODE_READY) ? r[20] : 1'b1;
        op.writeReg = (mode == MODE_READY) ? r[19] : 1'b1;
        op.phyDstRegNum = r[17:12];
        op.activeListPtr = r[10:6];
        return op;
    endfunction

    task automatic compareRegWrite(input int lane, input RegWrite actual, input RegWrite expected);
        checkCount++;
        if (actual.we !== expected.we) begin
            $display("error: regWrite[%0d].we actual %h expected %h", lane, actual.we, expected.we);
            errorCount++;
        end else if (expected.we && actual.regNum !== expected.regNum) begin
            $display("error: regWrite[%0d].regNum actual %h expected %h",
                     lane, actual.regNum, expected.regNum);
            errorCount++;
        end else if (expected.we && actual.data !== expected.data) begin
            $display("error: regWrite[%0d].data actual %h expected %h",
                     lane, actual.data, expected.data);
            errorCount++;
        end
    endtask

    task automatic compareActiveListWrite(input int lane, input ActiveListWrite actual,
                                          input ActiveListWrite expected);
        checkCount++;
        if (actual.write !== expected.write || actual.state !== expected.state) begin
            $display("error: activeListWrite[%0d].write/state actual %h/%h expected %h/%h",
                     lane, actual.write, actual.state, expected.write, expected.state);
            errorCount++;
        end else if (expected.write && actual.ptr !== expected.ptr) begin
            $display("error: activeListWrite[%0d].ptr actual %h expected %h",
                     lane, actual.ptr, expected.ptr);
            errorCount++;
        end
    endtask

    // Shadow pipeline advances with the inputs the DUT saw at this edge
    task automatic modelStep();
        for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
            if (!curRstN) begin
                for (int s = 0; s < 3; s++) shadow[i][s].valid = 1'b0;
            end else if (!curStall) begin
                shadow[i][2] = shadow[i][1];
                shadow[i][1] = shadow[i][0];
                shadow[i][0].valid = curIssue[i].valid;
                shadow[i][0].dataValid = curIssue[i].operandsReady;
                shadow[i][0].data = expectedData(curIssue[i].rawOp, curIssue[i].srcA,
                                                 curIssue[i].srcB);
                shadow[i][0].writeReg = curIssue[i].writeReg;
                shadow[i][0].regNum = curIssue[i].phyDstRegNum;
                shadow[i][0].ptr = curIssue[i].activeListPtr;
                for (int s = 0; s < 3; s++) shadow[i][s].valid = shadow[i][s].valid && !curClear;
            end
        end
    endtask

    task automatic checkOutputs();
        ShadowEntry s;
        RegWrite expReg;
        ActiveListWrite expAl;
        logic update;
        for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
            s = shadow[i][2];
            update = !curStall && !curClear && s.valid && !ptrInFlush(curRecovery, s.ptr);
            expReg.we = update && s.writeReg;
            expReg.regNum = s.regNum;
            expReg.data = s.data;
            expAl.write = update;
            expAl.ptr = s.ptr;
            expAl.state = (update && s.dataValid) ? EXEC_STATE_SUCCESS : EXEC_STATE_NOT_FINISHED;
            compareRegWrite(i, regWrite[i], expReg);
            compareActiveListWrite(i, activeListWrite[i], expAl);
        end
    endtask

    task automatic runCycle();
        @(posedge ctrl);
        modelStep();
        rstN <= nextRstN;
        stall <= nextStall;
        clear <= nextClear;
        recovery <= nextRecovery;
        for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
            issue[i] <= nextIssue[i];
            curIssue[i] = nextIssue[i];
        end
        curRstN = nextRstN;
        curStall = nextStall;
        curClear = nextClear;
        curRecovery = nextRecovery;
        @(negedge ctrl);
        checkOutputs();
    endtask

    task automatic runTest(input string name, input int cycles, input int mode);
        int startErrors;
        int startChecks;
        logic [31:0] r;
        startErrors = errorCount;
        startChecks = checkCount;
        for (int c = 0; c < cycles; c++) begin
            r = lcgNext();
            // Last cycles stay idle so in-flight ops retire in this test
            nextRstN = (mode != MODE_RESET) || (c >= 4);
            nextStall = (mode == MODE_STALL) && (c < cycles - 4) && (r[31:30] == 2'd0);
            nextClear = (mode == MODE_STALL) && (c < cycles - 4) && (r[29:25] == 5'd0);
            if (mode == MODE_FLUSH && c < cycles - 4) begin
                if (windowLeft == 0) begin
                    windowLeft = 1 + r[18:16];
                    nextRecovery.toRecoveryPhase = r[15];
                    nextRecovery.flushHeadPtr = r[14:10];
                    nextRecovery.flushTailPtr = r[9] ? r[14:10] : r[8:4];
                end
                windowLeft--;
            end else begin
                nextRecovery = '0;
            end
            for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
                nextIssue[i] = randomIssue(mode);
                if (mode == MODE_RESET || nextStall || c >= cycles - 4) nextIssue[i].valid = 1'b0;
            end
            runCycle();
        end
        $display("test %s: %0d checks, %0d errors", name,
                 checkCount - startChecks, errorCount - startErrors);
    endtask

    initial begin
        lcgState = 32'hb58c_9814;
        windowLeft = 0;
        checkCount = 0;
        errorCount = 0;
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        recovery = '0;
        curRstN = 1'b0;
        curStall = 1'b0;
        curClear = 1'b0;
        curRecovery = '0;
        for (int i = 0; i < COMPLEX_ISSUE_WIDTH; i++) begin
            issue[i] = '0;
            curIssue[i] = '0;
            nextIssue[i] = '0;
            for (int s = 0; s < 3; s++) shadow[i][s] = '0;
        end
        runTest("reset", 12, MODE_RESET);
        runTest("arithmetic", 300, MODE_ARITH);
        runTest("readiness", 150, MODE_READY);
        runTest("stallClear", 250, MODE_STALL);
        runTest("selectiveFlush", 250, MODE_FLUSH);
        $display("total checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
